//--- Bender.yml
package:
  name: gf_mul

sources:
  - files:
      - gf_field_pkg.sv
      - wb_bus_pkg.sv
      - clmul_split.sv
      - clmul_16.sv
      - clmul_combine.sv
      - gf_reduce.sv
      - gf_mul_regs.sv
      - gf_mul_top.sv
  - target: test
    files:
      - gf_mul_checker.sv
      - gf_mul_assert.sv
      - tb_gf_mul.sv

//--- clmul_16.sv
// One cycle latency; the product register only loads while valid is high
`default_nettype none
`timescale 1ns/100ps

module clmul_16
   import gf_field_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  gf_half_t    a,
   input  gf_half_t    b,
   input  logic        valid,
   output gf_partial_t p,
   output logic        p_valid
);

   gf_partial_t prod_c;

   // Schoolbook carry-less multiply, one shifted copy of a per set bit of b
   always_comb begin
      prod_c = '0;
      for (int i = 0; i < GF_HALF; i++) begin
         if (b[i]) begin
            prod_c = prod_c ^ (gf_partial_t'(a) << i);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         p       <= '0;
         p_valid <= 1'b0;
      end else begin
         p_valid <= valid;
         if (valid) begin
            p <= prod_c;
         end
      end
   end

endmodule

`default_nettype wire

//--- clmul_combine.sv
// Combinational; expects z1 to be the product of the XOR-folded halves
`default_nettype none
`timescale 1ns/100ps

module clmul_combine
   import gf_field_pkg::*;
(
   input  gf_partial_t z0,
   input  gf_partial_t z1,
   input  gf_partial_t z2,
   output gf_product_t product
);

   gf_partial_t mid;
   gf_product_t z0_ext;
   gf_product_t mid_ext;
   gf_product_t z2_ext;

   // In GF(2) subtraction is XOR, so the cross term is z1 minus z0 and z2
   assign mid = z0 ^ z1 ^ z2;

   assign z0_ext  = gf_product_t'(z0);
   assign mid_ext = gf_product_t'(mid) << GF_HALF;
   assign z2_ext  = gf_product_t'(z2) << GF_WIDTH;

   // The three terms overlap in bits 16 to 46
   assign product = z0_ext ^ mid_ext ^ z2_ext;

endmodule

`default_nettype wire

//--- clmul_split.sv
// Purely combinational; start is forwarded unchanged so lane data and valid stay aligned
`default_nettype none
`timescale 1ns/100ps

module clmul_split
   import gf_field_pkg::*;
(
   input  gf_operand_u op_a,
   input  gf_operand_u op_b,
   input  logic        start,
   output gf_half_t    lane_a [GF_LANES],
   output gf_half_t    lane_b [GF_LANES],
   output logic        lane_valid
);

   // Lane 0 multiplies the low halves
   assign lane_a[0] = op_a.halves.lo;
   assign lane_b[0] = op_b.halves.lo;

   // Lane 1 takes the folded halves for the Karatsuba middle term
   assign lane_a[1] = op_a.halves.lo ^ op_a.halves.hi;
   assign lane_b[1] = op_b.halves.lo ^ op_b.halves.hi;

   // Lane 2 multiplies the high halves
   assign lane_a[2] = op_a.halves.hi;
   assign lane_b[2] = op_b.halves.hi;

   assign lane_valid = start;

endmodule

`default_nettype wire

//--- gf_field_pkg.sv
// Widths are fixed for GF(2^32) with 16-bit Karatsuba halves; changing GF_WIDTH alone is not supported
`default_nettype none

package gf_field_pkg;

   localparam int GF_WIDTH  = 32;
   localparam int GF_HALF   = GF_WIDTH / 2;
   localparam int GF_PROD_W = 2 * GF_WIDTH - 1;
   localparam int GF_PART_W = 2 * GF_HALF - 1;

   // Low, middle and high Karatsuba terms
   localparam int GF_LANES  = 3;

   typedef logic [GF_HALF-1:0]   gf_half_t;
   typedef logic [GF_PART_W-1:0] gf_partial_t;
   typedef logic [GF_PROD_W-1:0] gf_product_t;
   typedef logic [GF_WIDTH-1:0]  gf_word_t;

   typedef struct packed {
      gf_half_t hi;
      gf_half_t lo;
   } gf_halves_t;

   // The bus sees a whole word, the multiplier sees two halves
   typedef union packed {
      gf_word_t   word;
      gf_halves_t halves;
   } gf_operand_u;

endpackage

`default_nettype wire

//--- gf_mul_assert.sv
// Covers the slave side of the Wishbone classic handshake only; bound into every gf_mul_regs
`default_nettype none
`timescale 1ns/100ps

module gf_mul_assert (
   input logic clk,
   input logic rst,
   input logic cyc,
   input logic stb,
   input logic ack
);

   int fail_count = 0;

   // Ack answers a live request only
   ack_in_cycle: assert property (@(posedge clk) disable iff (rst) ack |-> (cyc && stb))
      else begin
         fail_count++;
         $error("ack raised without cyc and stb");
      end

   ack_one_cycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
      else begin
         fail_count++;
         $error("ack held high for two cycles");
      end

   ack_low_after_reset: assert property (@(posedge clk) rst |=> !ack)
      else begin
         fail_count++;
         $error("ack high in the cycle after reset");
      end

endmodule

bind gf_mul_regs gf_mul_assert u_gf_mul_assert (
   .clk (clk),
   .rst (rst),
   .cyc (wb_req.cyc),
   .stb (wb_req.stb),
   .ack (wb_rsp.ack)
);

`default_nettype wire

//--- gf_mul_checker.sv
// Expects the master to hold each request until the edge after ack; exp_prod and exp_res set before OPB
`default_nettype none
`timescale 1ns/100ps

module gf_mul_checker
   import gf_field_pkg::*;
   import wb_bus_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  wb_req_t     wb_req,
   input  wb_rsp_t     wb_rsp,
   input  logic [63:0] test_name,
   input  gf_product_t exp_prod,
   input  gf_word_t    exp_res,
   output int          data_errors,
   output int          latency_errors
);

   wb_req_t     req_q;
   logic [63:0] name_q;
   gf_word_t    opa_m;
   gf_word_t    opb_m;
   gf_product_t prod_m;
   gf_word_t    res_m;
   logic        idle_m;
   int          wait_cycles;

   task automatic check_ack(input wb_req_t req, input logic [WB_DAT_W-1:0] dat);
      logic                result_rd;
      logic [WB_DAT_W-1:0] exp_dat;
      logic [WB_DAT_W-1:0] mask;
      result_rd = !req.we && (req.adr == REG_PROD_LO || req.adr == REG_PROD_HI ||
                              req.adr == REG_RESULT);
      // Only a result read during a multiply may wait longer than one cycle
      if (wait_cycles != 1 && !(result_rd && !idle_m)) begin
         latency_errors++;
         $display("Late ack in %s: address %0d was answered after %0d cycles instead of 1",
                  name_q, req.adr, wait_cycles);
      end
      if (req.we) begin
         if (req.adr == REG_OPA) begin
            opa_m = req.dat_w;
         end
         if (req.adr == REG_OPB) begin
            opb_m  = req.dat_w;
            prod_m = exp_prod;
            res_m  = exp_res;
            idle_m = 1'b0;
         end
      end else begin
         mask = '1;
         case (req.adr)
            REG_OPA:     exp_dat = opa_m;
            REG_OPB:     exp_dat = opb_m;
            REG_PROD_LO: exp_dat = prod_m[WB_DAT_W-1:0];
            REG_PROD_HI: exp_dat = {1'b0, prod_m[GF_PROD_W-1:WB_DAT_W]};
            REG_RESULT:  exp_dat = res_m;
            default:     exp_dat = '0;
         endcase
         // Busy is unknown until a result read has completed
         if (req.adr == REG_STATUS && !idle_m) begin
            mask[STATUS_BUSY_BIT] = 1'b0;
         end
         if ((dat & mask) !== (exp_dat & mask)) begin
            data_errors++;
            $display("Error in %s: address %0d expected %h, actual %h",
                     name_q, req.adr, exp_dat & mask, dat & mask);
         end
         if (result_rd) begin
            idle_m = 1'b1;
         end
      end
   endtask

   always @(posedge clk) begin
      if (rst) begin
         opa_m          = '0;
         opb_m          = '0;
         prod_m         = '0;
         res_m          = '0;
         idle_m         = 1'b1;
         wait_cycles    = 0;
         data_errors    = 0;
         latency_errors = 0;
      end else if (wb_rsp.ack) begin
         check_ack(req_q, wb_rsp.dat_r);
         wait_cycles = 0;
      end else if (wb_req.cyc && wb_req.stb) begin
         wait_cycles++;
      end
      req_q  = wb_req;
      name_q = test_name;
   end

endmodule

`default_nettype wire

//--- gf_mul_regs.sv
// Result reads stall while busy; at most two multiplies are in flight between start and done
`default_nettype none
`timescale 1ns/100ps

module gf_mul_regs
   import gf_field_pkg::*;
   import wb_bus_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  wb_req_t     wb_req,
   output wb_rsp_t     wb_rsp,
   output gf_operand_u op_a,
   output gf_operand_u op_b,
   output logic        start,
   input  logic        done,
   input  gf_product_t product,
   input  gf_word_t    result
);

   logic                ack_q;
   logic [WB_DAT_W-1:0] dat_q;
   logic [WB_DAT_W-1:0] rd_data;
   logic [1:0]          pending;
   logic                busy;
   logic                req_new;
   logic                result_rd;
   logic                can_ack;
   logic                issue;
   gf_product_t         prod_q;
   gf_word_t            result_q;

   assign busy = (pending != 2'd0);

   // A request is new until its ack has been given
   assign req_new = wb_req.cyc && wb_req.stb && !ack_q;

   assign result_rd = !wb_req.we && (wb_req.adr == REG_PROD_LO ||
                                     wb_req.adr == REG_PROD_HI ||
                                     wb_req.adr == REG_RESULT);

   assign can_ack = req_new && !(result_rd && busy);
   assign issue   = can_ack && wb_req.we && (wb_req.adr == REG_OPB);

   always_comb begin
      rd_data = '0;
      case (wb_req.adr)
         REG_OPA:     rd_data = op_a.word;
         REG_OPB:     rd_data = op_b.word;
         REG_PROD_LO: rd_data = prod_q[WB_DAT_W-1:0];
         REG_PROD_HI: rd_data = {1'b0, prod_q[GF_PROD_W-1:WB_DAT_W]};
         REG_RESULT:  rd_data = result_q;
         REG_STATUS:  rd_data[STATUS_BUSY_BIT] = busy;
         default:     rd_data = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         ack_q    <= 1'b0;
         dat_q    <= '0;
         op_a     <= '0;
         op_b     <= '0;
         start    <= 1'b0;
         pending  <= 2'd0;
         prod_q   <= '0;
         result_q <= '0;
      end else begin
         ack_q <= can_ack;
         start <= issue;
         if (can_ack && !wb_req.we) begin
            dat_q <= rd_data;
         end
         if (can_ack && wb_req.we && wb_req.adr == REG_OPA) begin
            op_a.word <= wb_req.dat_w;
         end
         if (issue) begin
            op_b.word <= wb_req.dat_w;
         end
         if (done) begin
            prod_q   <= product;
            result_q <= result;
         end
         // Start and done on the same edge leave the count unchanged
         case ({issue, done})
            2'b10:   pending <= pending + 2'd1;
            2'b01:   pending <= pending - 2'd1;
            default: pending <= pending;
         endcase
      end
   end

   assign wb_rsp.ack   = ack_q;
   assign wb_rsp.dat_r = dat_q;

endmodule

`default_nettype wire

//--- gf_mul_top.sv
// Two-cycle multiply latency from the REG_OPB write; FIELD_POLY must not include the x^32 term
`default_nettype none
`timescale 1ns/100ps

module gf_mul_top
   import gf_field_pkg::*;
   import wb_bus_pkg::*;
#(
   parameter gf_word_t FIELD_POLY = 32'h0000_008D
) (
   input  logic    clk,
   input  logic    rst,
   input  wb_req_t wb_req,
   output wb_rsp_t wb_rsp
);

   gf_operand_u   op_a;
   gf_operand_u   op_b;
   logic          start;
   gf_half_t      lane_a [GF_LANES];
   gf_half_t      lane_b [GF_LANES];
   logic          lane_valid;
   gf_partial_t   z [GF_LANES];
   logic [GF_LANES-1:0] z_valid;
   gf_product_t   product_raw;
   gf_product_t   product_q;
   gf_word_t      result;
   logic          done;

   gf_mul_regs u_gf_mul_regs (
      .clk     (clk),
      .rst     (rst),
      .wb_req  (wb_req),
      .wb_rsp  (wb_rsp),
      .op_a    (op_a),
      .op_b    (op_b),
      .start   (start),
      .done    (done),
      .product (product_q),
      .result  (result)
   );

   clmul_split u_clmul_split (
      .op_a       (op_a),
      .op_b       (op_b),
      .start      (start),
      .lane_a     (lane_a),
      .lane_b     (lane_b),
      .lane_valid (lane_valid)
   );

   for (genvar i = 0; i < GF_LANES; i++) begin : g_lane
      clmul_16 u_clmul_16 (
         .clk     (clk),
         .rst     (rst),
         .a       (lane_a[i]),
         .b       (lane_b[i]),
         .valid   (lane_valid),
         .p       (z[i]),
         .p_valid (z_valid[i])
      );
   end

   clmul_combine u_clmul_combine (
      .z0      (z[0]),
      .z1      (z[1]),
      .z2      (z[2]),
      .product (product_raw)
   );

   gf_reduce #(
      .FIELD_POLY (FIELD_POLY)
   ) u_gf_reduce (
      .clk       (clk),
      .rst       (rst),
      .product   (product_raw),
      .valid     (&z_valid),
      .product_q (product_q),
      .result    (result),
      .done      (done)
   );

endmodule

`default_nettype wire

//--- gf_reduce.sv
// FIELD_POLY is the tail below x^32, the x^32 term is implied; one cycle latency
`default_nettype none
`timescale 1ns/100ps

module gf_reduce
   import gf_field_pkg::*;
#(
   parameter gf_word_t FIELD_POLY = 32'h0000_008D
) (
   input  logic        clk,
   input  logic        rst,
   input  gf_product_t product,
   input  logic        valid,
   output gf_product_t product_q,
   output gf_word_t    result,
   output logic        done
);

   gf_product_t rem;

   // Fold from the top bit down, each fold only disturbs bits below it
   always_comb begin
      rem = product;
      for (int i = GF_PROD_W - 1; i >= GF_WIDTH; i--) begin
         if (rem[i]) begin
            rem = rem ^ (gf_product_t'(1) << i)
                      ^ (gf_product_t'(FIELD_POLY) << (i - GF_WIDTH));
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         product_q <= '0;
         result    <= '0;
         done      <= 1'b0;
      end else begin
         done <= valid;
         if (valid) begin
            product_q <= product;
            result    <= rem[GF_WIDTH-1:0];
         end
      end
   end

endmodule

`default_nettype wire

//--- project.f
gf_field_pkg.sv
wb_bus_pkg.sv
clmul_split.sv
clmul_16.sv
clmul_combine.sv
gf_reduce.sv
gf_mul_regs.sv
gf_mul_top.sv
gf_mul_checker.sv
gf_mul_assert.sv
tb_gf_mul.sv

//--- tb_gf_mul.sv
// Hand-written expected values assume the default FIELD_POLY of 32'h8D; stops itself on timeout
`default_nettype none
`timescale 1ns/100ps

module tb_gf_mul
   import gf_field_pkg::*;
   import wb_bus_pkg::*;
();

   localparam gf_word_t FIELD_POLY     = 32'h0000_008D;
   localparam int       NUM_HAND       = 5;
   localparam int       NUM_ROWS       = NUM_HAND + 12;
   localparam int       TIMEOUT_CYCLES = NUM_ROWS * 40 + 200;

   typedef struct packed {
      logic [63:0] name;
      gf_word_t    a;
      gf_word_t    b;
      gf_product_t prod;
      gf_word_t    res;
   } row_t;

   logic        clk;
   logic        rst;
   wb_req_t     wb_req;
   wb_rsp_t     wb_rsp;
   logic [63:0] test_name;
   gf_product_t exp_prod;
   gf_word_t    exp_res;
   int          data_errors;
   int          latency_errors;
   int          assert_fails;
   int          cycle_count;
   int          seed;
   row_t        rows [NUM_ROWS];

   gf_mul_top #(
      .FIELD_POLY (FIELD_POLY)
   ) u_gf_mul_top (
      .clk    (clk),
      .rst    (rst),
      .wb_req (wb_req),
      .wb_rsp (wb_rsp)
   );

   gf_mul_checker u_gf_mul_checker (
      .clk            (clk),
      .rst            (rst),
      .wb_req         (wb_req),
      .wb_rsp         (wb_rsp),
      .test_name      (test_name),
      .exp_prod       (exp_prod),
      .exp_res        (exp_res),
      .data_errors    (data_errors),
      .latency_errors (latency_errors)
   );

   // Raw carry-less product built one bit pair at a time
   function automatic gf_product_t clmul_ref(input gf_word_t a, input gf_word_t b);
      gf_product_t p;
      p = '0;
      for (int i = 0; i < GF_WIDTH; i++) begin
         for (int j = 0; j < GF_WIDTH; j++) begin
            if (a[i] && b[j]) begin
               p[i + j] = !p[i + j];
            end
         end
      end
      return p;
   endfunction

   // Field multiply by shift and add with a reduction after every shift
   function automatic gf_word_t gf_mul_ref(input gf_word_t a, input gf_word_t b);
      gf_word_t acc;
      logic     carry;
      acc = '0;
      for (int i = GF_WIDTH - 1; i >= 0; i--) begin
         carry = acc[GF_WIDTH-1];
         acc   = acc << 1;
         if (carry) begin
            acc = acc ^ FIELD_POLY;
         end
         if (b[i]) begin
            acc = acc ^ a;
         end
      end
      return acc;
   endfunction

   task automatic wait_ack();
      @(negedge clk);
      while (!wb_rsp.ack) begin
         @(negedge clk);
      end
   endtask

   task automatic bus_write(input logic [WB_ADR_W-1:0] adr, input gf_word_t data);
      @(negedge clk);
      wb_req.cyc   = 1'b1;
      wb_req.stb   = 1'b1;
      wb_req.we    = 1'b1;
      wb_req.adr   = adr;
      wb_req.dat_w = data;
      wait_ack();
   endtask

   task automatic bus_read(input logic [WB_ADR_W-1:0] adr);
      @(negedge clk);
      wb_req.cyc   = 1'b1;
      wb_req.stb   = 1'b1;
      wb_req.we    = 1'b0;
      wb_req.adr   = adr;
      wb_req.dat_w = '0;
      wait_ack();
   endtask

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Run timed out after %0d cycles, the DUT never answered", cycle_count);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      rst          = 1'b1;
      wb_req       = '0;
      test_name    = "reset   ";
      exp_prod     = '0;
      exp_res      = '0;
      assert_fails = 0;
      seed         = 32'heb467c5d;

      rows[0] = {"zero    ", 32'h0, 32'h1234_5678, 63'h0, 32'h0};
      rows[1] = {"one     ", 32'h1, 32'hDEAD_BEEF, 63'hDEAD_BEEF, 32'hDEAD_BEEF};
      rows[2] = {"ones_x2 ", 32'hFFFF_FFFF, 32'h2, 63'h1_FFFF_FFFE, 32'hFFFF_FF73};
      rows[3] = {"msb_msb ", 32'h8000_0000, 32'h8000_0000, 63'h4000_0000_0000_0000,
                 32'h4000_1037};
      rows[4] = {"known   ", 32'h3, 32'h8000_0001, 63'h1_8000_0003, 32'h8000_008E};
      for (int i = NUM_HAND; i < NUM_ROWS; i++) begin
         rows[i].name = {"rand_", 8'h30 + 8'((i - NUM_HAND) / 10),
                         8'h30 + 8'((i - NUM_HAND) % 10), " "};
         rows[i].a    = $random(seed);
         rows[i].b    = $random(seed);
         rows[i].prod = clmul_ref(rows[i].a, rows[i].b);
         rows[i].res  = gf_mul_ref(rows[i].a, rows[i].b);
      end

      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      for (int r = 0; r <= 5; r++) begin
         bus_read(4'(r));
      end

      // Result is read straight after the start so the stalled read is exercised
      for (int i = 0; i < NUM_ROWS; i++) begin
         test_name = rows[i].name;
         exp_prod  = rows[i].prod;
         exp_res   = rows[i].res;
         bus_write(REG_OPA, rows[i].a);
         bus_write(REG_OPB, rows[i].b);
         bus_read(REG_RESULT);
         bus_read(REG_PROD_LO);
         bus_read(REG_PROD_HI);
         bus_read(REG_OPA);
         bus_read(REG_OPB);
         bus_read(REG_STATUS);
      end

      test_name = "unmapped";
      bus_write(4'hF, 32'hA5A5_A5A5);
      bus_read(4'hF);
      bus_read(4'h9);
      for (int r = 0; r <= 5; r++) begin
         bus_read(4'(r));
      end

      @(negedge clk);
      wb_req = '0;
      repeat (3) @(negedge clk);

      assert_fails = u_gf_mul_top.u_gf_mul_regs.u_gf_mul_assert.fail_count;
      $display("Checks done: %0d data errors, %0d latency errors, %0d assertion failures",
               data_errors, latency_errors, assert_fails);
      if (data_errors == 0 && latency_errors == 0 && assert_fails == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- wb_bus_pkg.sv
// Wishbone classic only: word addressing, no byte selects, no pipelined mode
`default_nettype none

package wb_bus_pkg;

   localparam int WB_ADR_W = 4;
   localparam int WB_DAT_W = 32;

   typedef struct packed {
      logic                cyc;
      logic                stb;
      logic                we;
      logic [WB_ADR_W-1:0] adr;
      logic [WB_DAT_W-1:0] dat_w;
   } wb_req_t;

   typedef struct packed {
      logic                ack;
      logic [WB_DAT_W-1:0] dat_r;
   } wb_rsp_t;

   // Register map, word addresses
   localparam logic [WB_ADR_W-1:0] REG_OPA     = 4'd0;
   localparam logic [WB_ADR_W-1:0] REG_OPB     = 4'd1;
   localparam logic [WB_ADR_W-1:0] REG_PROD_LO = 4'd2;
   localparam logic [WB_ADR_W-1:0] REG_PROD_HI = 4'd3;
   localparam logic [WB_ADR_W-1:0] REG_RESULT  = 4'd4;
   localparam logic [WB_ADR_W-1:0] REG_STATUS  = 4'd5;

   // Position of busy inside REG_STATUS
   localparam int STATUS_BUSY_BIT = 0;

endpackage

`default_nettype wire
